// File: hw/loader_pkg.sv
// Widths, download codes and button positions assume the 20-bit host joystick layout and 27-bit SDRAM space
package loader_pkg;

	// ====================
	// Widths
	// ====================
	localparam int HALF_W     = 16;
	localparam int WORD_W     = 32;
	localparam int ADDR_W     = 27;
	localparam int PIF_ADDR_W = 9;
	localparam int JOY_W      = 20;
	localparam int NUM_PADS   = 4;

	// ====================
	// Types
	// ====================
	typedef logic [HALF_W-1:0]     half_t;
	typedef logic [WORD_W-1:0]     word_t;
	typedef logic [ADDR_W-1:0]     addr_t;
	typedef logic [PIF_ADDR_W-1:0] pif_addr_t;
	typedef logic [JOY_W-1:0]      joy_t;
	// Bit 0 is player 1
	typedef logic [NUM_PADS-1:0]   pad_vec_t;

	// Cartridge image sits 8 MiB into SDRAM
	localparam addr_t CART_BASE = addr_t'(8388608);

	// Download index codes, low 6 bits of the host index
	localparam logic [5:0] IDX_PIFROM = 6'd0;
	localparam logic [5:0] IDX_CART   = 6'd1;

	// ====================
	// Joystick bits
	// ====================
	localparam int BTN_RIGHT   = 0;
	localparam int BTN_LEFT    = 1;
	localparam int BTN_DOWN    = 2;
	localparam int BTN_UP      = 3;
	localparam int BTN_A       = 4;
	localparam int BTN_B       = 5;
	localparam int BTN_START   = 6;
	localparam int BTN_L       = 7;
	localparam int BTN_R       = 8;
	localparam int BTN_Z       = 9;
	localparam int BTN_C_UP    = 10;
	localparam int BTN_C_RIGHT = 11;
	localparam int BTN_C_DOWN  = 12;
	localparam int BTN_C_LEFT  = 13;
	// Held for the savestate menu
	localparam int SS_BUTTON   = 14;

endpackage

// File: hw/word_bus_if.sv
// Half-word write stream with no handshake; addr and data are only valid while wr is high
`timescale 1ns/1ns

interface word_bus_if;

	// Download for this target is running
	logic              active;
	// One-cycle write strobe
	logic              wr;
	// Host byte address, bit 1 selects the half
	loader_pkg::addr_t addr;
	loader_pkg::half_t data;

	modport ctrl (
		output active,
		output wr,
		output addr,
		output data
	);

	modport packer (
		input active,
		input wr,
		input addr,
		input data
	);

endinterface

// File: hw/download_ctrl.sv
// Host must not raise ioctl_wr while ioctl_wait is high; only index codes 0 and 1 are decoded
`timescale 1ns/1ns

module download_ctrl (
	input  logic              clk_1x,
	input  logic              rst,
	input  logic              ioctl_download,
	input  logic [7:0]        ioctl_index,
	input  loader_pkg::addr_t ioctl_addr,
	input  loader_pkg::half_t ioctl_dout,
	input  logic              ioctl_wr,
	input  logic              ram_ready,
	input  logic              img_mounted,
	input  logic              img_readonly,
	input  logic [31:0]       img_size,
	input  logic              bk_load_cmd,
	input  logic              bk_save_cmd,
	input  logic              autosave_off,
	input  logic              osd_status,
	input  logic              bk_pending,
	word_bus_if.ctrl          pif_bus,
	word_bus_if.ctrl          cart_bus,
	output logic              ioctl_wait,
	output logic              cart_loaded,
	output logic              use_img,
	output logic              bk_load,
	output logic              bk_save,
	output logic              led_busy
);

	logic              pif_active;
	logic              cart_active;
	logic              cart_active_d;
	logic              pif_wr;
	logic              cart_wr;
	logic              cart_hi_wr;
	loader_pkg::addr_t wr_addr;
	loader_pkg::half_t wr_data;

	// ====================
	// Target decode and forwarding
	// ====================
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			pif_active  <= 1'b0;
			cart_active <= 1'b0;
			pif_wr      <= 1'b0;
			cart_wr     <= 1'b0;
		end else begin
			pif_active  <= ioctl_download && (ioctl_index[5:0] == loader_pkg::IDX_PIFROM);
			cart_active <= ioctl_download && (ioctl_index[5:0] == loader_pkg::IDX_CART);
			// Strobe only reaches the bus whose download was already running
			pif_wr      <= pif_active && ioctl_wr;
			cart_wr     <= cart_active && ioctl_wr;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (ioctl_wr) begin
			wr_addr <= ioctl_addr;
			wr_data <= ioctl_dout;
		end
	end

	// Both buses share the same payload registers
	assign pif_bus.active  = pif_active;
	assign pif_bus.wr      = pif_wr;
	assign pif_bus.addr    = wr_addr;
	assign pif_bus.data    = wr_data;

	assign cart_bus.active = cart_active;
	assign cart_bus.wr     = cart_wr;
	assign cart_bus.addr   = wr_addr;
	assign cart_bus.data   = wr_data;

	// ====================
	// SDRAM wait level
	// ====================
	// High half on the cart bus means the packer fires ram_wr next edge
	assign cart_hi_wr = cart_wr && wr_addr[1];

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			ioctl_wait <= 1'b0;
		end else if (!cart_active) begin
			ioctl_wait <= 1'b0;
		end else if (cart_hi_wr) begin
			ioctl_wait <= 1'b1;
		end else if (ram_ready) begin
			ioctl_wait <= 1'b0;
		end
	end

	// ====================
	// Cart and backup flags
	// ====================
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			cart_active_d <= 1'b0;
			cart_loaded   <= 1'b0;
			use_img       <= 1'b0;
			bk_load       <= 1'b0;
			bk_save       <= 1'b0;
		end else begin
			cart_active_d <= cart_active;
			if (cart_active) begin
				cart_loaded <= 1'b1;
			end
			// New cart drops the old image; a writable mount wins if both happen
			if (cart_active && !cart_active_d) begin
				use_img <= 1'b0;
			end
			if (img_mounted && (img_size != '0) && !img_readonly) begin
				use_img <= 1'b1;
			end
			bk_load <= bk_load_cmd || (cart_active && img_mounted);
			bk_save <= bk_save_cmd || (osd_status && !autosave_off);
		end
	end

	assign led_busy = cart_active || bk_pending;

	// Host respects back-pressure from the SDRAM path
	a_no_wr_in_wait: assert property (@(posedge clk_1x) disable iff (rst)
		ioctl_wait |-> !ioctl_wr)
		else $error("ioctl_wr raised while ioctl_wait is high");

	// Packers never see overlapping downloads
	a_one_target: assert property (@(posedge clk_1x) disable iff (rst)
		!(pif_bus.active && cart_bus.active))
		else $error("both download targets active");

endmodule

// File: hw/word_packer.sv
// Low half must arrive before its high half; ports narrower than ADDR_W are taken as word addressed
`timescale 1ns/1ns

module word_packer #(
	parameter type               out_addr_t = loader_pkg::addr_t,
	parameter bit                SWAP_BYTES = 1'b0,
	parameter loader_pkg::addr_t BASE_ADDR  = '0
) (
	input  logic              clk_1x,
	input  logic              rst,
	word_bus_if.packer        bus,
	output out_addr_t         out_addr,
	output loader_pkg::word_t out_data,
	output logic              out_wr
);

	localparam int OUT_W     = $bits(out_addr_t);
	localparam bit WORD_ADDR = OUT_W < loader_pkg::ADDR_W;

	logic              half_wr;
	loader_pkg::addr_t byte_addr;
	out_addr_t         mapped_addr;
	loader_pkg::half_t in_half;

	assign half_wr   = bus.active && bus.wr;
	assign byte_addr = bus.addr + BASE_ADDR;

	// ====================
	// Address mapping
	// ====================
	generate
		if (WORD_ADDR) begin : g_word_addr
			// Drop the byte offset within the 32-bit word
			assign mapped_addr = byte_addr[OUT_W+1:2];
		end else begin : g_byte_addr
			assign mapped_addr = byte_addr[OUT_W-1:0];
		end
	endgenerate

	assign in_half = SWAP_BYTES ? {bus.data[7:0], bus.data[15:8]} : bus.data;

	// ====================
	// Half assembly
	// ====================
	always_ff @(posedge clk_1x) begin
		if (half_wr) begin
			if (!bus.addr[1]) begin
				out_addr <= mapped_addr;
				// Swapped words are fully byte reversed, so the halves trade places too
				if (SWAP_BYTES) begin
					out_data[31:16] <= in_half;
				end else begin
					out_data[15:0] <= in_half;
				end
			end else begin
				if (SWAP_BYTES) begin
					out_data[15:0] <= in_half;
				end else begin
					out_data[31:16] <= in_half;
				end
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			out_wr <= 1'b0;
		end else begin
			out_wr <= half_wr && bus.addr[1];
		end
	end

	// Each word needs two host writes, so strobes are never back to back
	a_no_double_wr: assert property (@(posedge clk_1x) disable iff (rst)
		out_wr |=> !out_wr)
		else $error("out_wr fired on consecutive cycles");

endmodule

// File: hw/pad_mapper.sv
// Purely combinational; player 1 reads all zero while its savestate button is held
`timescale 1ns/1ns

module pad_mapper (
	input  loader_pkg::joy_t     joy_0,
	input  loader_pkg::joy_t     joy_1,
	input  loader_pkg::joy_t     joy_2,
	input  loader_pkg::joy_t     joy_3,
	output loader_pkg::pad_vec_t pad_a,
	output loader_pkg::pad_vec_t pad_b,
	output loader_pkg::pad_vec_t pad_z,
	output loader_pkg::pad_vec_t pad_start,
	output loader_pkg::pad_vec_t pad_dpad_up,
	output loader_pkg::pad_vec_t pad_dpad_down,
	output loader_pkg::pad_vec_t pad_dpad_left,
	output loader_pkg::pad_vec_t pad_dpad_right,
	output loader_pkg::pad_vec_t pad_l,
	output loader_pkg::pad_vec_t pad_r,
	output loader_pkg::pad_vec_t pad_c_up,
	output loader_pkg::pad_vec_t pad_c_down,
	output loader_pkg::pad_vec_t pad_c_left,
	output loader_pkg::pad_vec_t pad_c_right
);

	// Index 0 is player 1
	loader_pkg::joy_t [loader_pkg::NUM_PADS-1:0] joys;

	// Gather one button across all players
	function automatic loader_pkg::pad_vec_t btn_vec(
		input loader_pkg::joy_t [loader_pkg::NUM_PADS-1:0] j,
		input int pos
	);
		loader_pkg::pad_vec_t v;
		for (int p = 0; p < loader_pkg::NUM_PADS; p++) begin
			v[p] = j[p][pos];
		end
		return v;
	endfunction

	// Savestate hotkey combos must not leak into the game
	assign joys[0] = joy_0[loader_pkg::SS_BUTTON] ? '0 : joy_0;
	assign joys[1] = joy_1;
	assign joys[2] = joy_2;
	assign joys[3] = joy_3;

	// ====================
	// Button vectors
	// ====================
	assign pad_a          = btn_vec(joys, loader_pkg::BTN_A);
	assign pad_b          = btn_vec(joys, loader_pkg::BTN_B);
	assign pad_z          = btn_vec(joys, loader_pkg::BTN_Z);
	assign pad_start      = btn_vec(joys, loader_pkg::BTN_START);
	assign pad_dpad_up    = btn_vec(joys, loader_pkg::BTN_UP);
	assign pad_dpad_down  = btn_vec(joys, loader_pkg::BTN_DOWN);
	assign pad_dpad_left  = btn_vec(joys, loader_pkg::BTN_LEFT);
	assign pad_dpad_right = btn_vec(joys, loader_pkg::BTN_RIGHT);
	assign pad_l          = btn_vec(joys, loader_pkg::BTN_L);
	assign pad_r          = btn_vec(joys, loader_pkg::BTN_R);
	assign pad_c_up       = btn_vec(joys, loader_pkg::BTN_C_UP);
	assign pad_c_down     = btn_vec(joys, loader_pkg::BTN_C_DOWN);
	assign pad_c_left     = btn_vec(joys, loader_pkg::BTN_C_LEFT);
	assign pad_c_right    = btn_vec(joys, loader_pkg::BTN_C_RIGHT);

endmodule

// File: hw/core_loader_top.sv
// SDRAM must answer each ram_wr with a ram_ready pulse; boot-ROM writes are taken without back-pressure
`timescale 1ns/1ns

module core_loader_top #(
	parameter loader_pkg::addr_t CART_OFFSET = loader_pkg::CART_BASE
) (
	input  logic                 clk_1x,
	input  logic                 rst,
	input  logic                 ioctl_download,
	input  logic [7:0]           ioctl_index,
	input  loader_pkg::addr_t    ioctl_addr,
	input  loader_pkg::half_t    ioctl_dout,
	input  logic                 ioctl_wr,
	input  logic                 ram_ready,
	input  logic                 img_mounted,
	input  logic                 img_readonly,
	input  logic [31:0]          img_size,
	input  logic                 bk_load_cmd,
	input  logic                 bk_save_cmd,
	input  logic                 autosave_off,
	input  logic                 osd_status,
	input  logic                 bk_pending,
	input  loader_pkg::joy_t     joy_0,
	input  loader_pkg::joy_t     joy_1,
	input  loader_pkg::joy_t     joy_2,
	input  loader_pkg::joy_t     joy_3,
	output logic                 ioctl_wait,
	output loader_pkg::pif_addr_t pifrom_wraddress,
	output loader_pkg::word_t    pifrom_wrdata,
	output logic                 pifrom_wren,
	output loader_pkg::addr_t    ram_addr,
	output loader_pkg::word_t    ram_data,
	output logic                 ram_wr,
	output logic                 cart_loaded,
	output logic                 use_img,
	output logic                 bk_load,
	output logic                 bk_save,
	output logic                 led_busy,
	output loader_pkg::pad_vec_t pad_a,
	output loader_pkg::pad_vec_t pad_b,
	output loader_pkg::pad_vec_t pad_z,
	output loader_pkg::pad_vec_t pad_start,
	output loader_pkg::pad_vec_t pad_dpad_up,
	output loader_pkg::pad_vec_t pad_dpad_down,
	output loader_pkg::pad_vec_t pad_dpad_left,
	output loader_pkg::pad_vec_t pad_dpad_right,
	output loader_pkg::pad_vec_t pad_l,
	output loader_pkg::pad_vec_t pad_r,
	output loader_pkg::pad_vec_t pad_c_up,
	output loader_pkg::pad_vec_t pad_c_down,
	output loader_pkg::pad_vec_t pad_c_left,
	output loader_pkg::pad_vec_t pad_c_right
);

	word_bus_if pif_bus ();
	word_bus_if cart_bus ();

	// ====================
	// Download path
	// ====================
	download_ctrl download_ctrl_inst (
		.clk_1x         (clk_1x),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.ram_ready      (ram_ready),
		.img_mounted    (img_mounted),
		.img_readonly   (img_readonly),
		.img_size       (img_size),
		.bk_load_cmd    (bk_load_cmd),
		.bk_save_cmd    (bk_save_cmd),
		.autosave_off   (autosave_off),
		.osd_status     (osd_status),
		.bk_pending     (bk_pending),
		.pif_bus        (pif_bus.ctrl),
		.cart_bus       (cart_bus.ctrl),
		.ioctl_wait     (ioctl_wait),
		.cart_loaded    (cart_loaded),
		.use_img        (use_img),
		.bk_load        (bk_load),
		.bk_save        (bk_save),
		.led_busy       (led_busy)
	);

	// Boot ROM wants big-endian words at word addresses
	word_packer #(
		.out_addr_t (loader_pkg::pif_addr_t),
		.SWAP_BYTES (1'b1),
		.BASE_ADDR  ('0)
	) pif_packer_inst (
		.clk_1x   (clk_1x),
		.rst      (rst),
		.bus      (pif_bus.packer),
		.out_addr (pifrom_wraddress),
		.out_data (pifrom_wrdata),
		.out_wr   (pifrom_wren)
	);

	word_packer #(
		.out_addr_t (loader_pkg::addr_t),
		.SWAP_BYTES (1'b0),
		.BASE_ADDR  (CART_OFFSET)
	) cart_packer_inst (
		.clk_1x   (clk_1x),
		.rst      (rst),
		.bus      (cart_bus.packer),
		.out_addr (ram_addr),
		.out_data (ram_data),
		.out_wr   (ram_wr)
	);

	// ====================
	// Controllers
	// ====================
	pad_mapper pad_mapper_inst (
		.joy_0          (joy_0),
		.joy_1          (joy_1),
		.joy_2          (joy_2),
		.joy_3          (joy_3),
		.pad_a          (pad_a),
		.pad_b          (pad_b),
		.pad_z          (pad_z),
		.pad_start      (pad_start),
		.pad_dpad_up    (pad_dpad_up),
		.pad_dpad_down  (pad_dpad_down),
		.pad_dpad_left  (pad_dpad_left),
		.pad_dpad_right (pad_dpad_right),
		.pad_l          (pad_l),
		.pad_r          (pad_r),
		.pad_c_up       (pad_c_up),
		.pad_c_down     (pad_c_down),
		.pad_c_left     (pad_c_left),
		.pad_c_right    (pad_c_right)
	);

endmodule

// File: test/tb_clock_gen.sv
// Free-running 8 ns clock; reset is held high for the first RESET_CYCLES rising edges
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic clk_1x,
	output logic rst
);

	initial begin
		clk_1x = 1'b0;
		forever #HALF_PERIOD clk_1x = ~clk_1x;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_1x);
		rst <= 1'b0;
	end

endmodule

// File: test/tb_core_loader.sv
// Self-checking testbench; SDRAM ready is modeled 1 to 5 cycles after each ram_wr, stops at first error
`timescale 1ns/1ns

module tb_core_loader;

	localparam int WAIT_LIMIT = 64;
	localparam int PAIR_COUNT = 8;
	localparam int RUN_LIMIT  = 5000;

	logic                 clk_1x;
	logic                 rst;
	logic                 ioctl_download;
	logic [7:0]           ioctl_index;
	loader_pkg::addr_t    ioctl_addr;
	loader_pkg::half_t    ioctl_dout;
	logic                 ioctl_wr;
	logic                 ram_ready;
	logic                 img_mounted;
	logic                 img_readonly;
	logic [31:0]          img_size;
	logic                 bk_load_cmd;
	logic                 bk_save_cmd;
	logic                 autosave_off;
	logic                 osd_status;
	logic                 bk_pending;
	loader_pkg::joy_t     joy_0;
	loader_pkg::joy_t     joy_1;
	loader_pkg::joy_t     joy_2;
	loader_pkg::joy_t     joy_3;
	logic                 ioctl_wait;
	loader_pkg::pif_addr_t pifrom_wraddress;
	loader_pkg::word_t    pifrom_wrdata;
	logic                 pifrom_wren;
	loader_pkg::addr_t    ram_addr;
	loader_pkg::word_t    ram_data;
	logic                 ram_wr;
	logic                 cart_loaded;
	logic                 use_img;
	logic                 bk_load;
	logic                 bk_save;
	logic                 led_busy;
	loader_pkg::pad_vec_t pad_a;
	loader_pkg::pad_vec_t pad_b;
	loader_pkg::pad_vec_t pad_z;
	loader_pkg::pad_vec_t pad_start;
	loader_pkg::pad_vec_t pad_dpad_up;
	loader_pkg::pad_vec_t pad_dpad_down;
	loader_pkg::pad_vec_t pad_dpad_left;
	loader_pkg::pad_vec_t pad_dpad_right;
	loader_pkg::pad_vec_t pad_l;
	loader_pkg::pad_vec_t pad_r;
	loader_pkg::pad_vec_t pad_c_up;
	loader_pkg::pad_vec_t pad_c_down;
	loader_pkg::pad_vec_t pad_c_left;
	loader_pkg::pad_vec_t pad_c_right;

	// Player 1 bit of every button vector
	logic [13:0]          p1_bits;
	integer               seed = 32'h0c4f_1763;
	int                   wait_count;
	int                   ready_delay;

	tb_clock_gen clock_gen_inst (
		.clk_1x (clk_1x),
		.rst    (rst)
	);

	core_loader_top core_loader_top_inst (.*);

	assign p1_bits = {pad_a[0], pad_b[0], pad_z[0], pad_start[0], pad_dpad_up[0],
		pad_dpad_down[0], pad_dpad_left[0], pad_dpad_right[0], pad_l[0], pad_r[0],
		pad_c_up[0], pad_c_down[0], pad_c_left[0], pad_c_right[0]};

	// ====================
	// Reporting
	// ====================
	task automatic report_mismatch(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("Error: %s expected 0x%0h actual 0x%0h", test, expected, actual);
		$display("TESTS FAILED");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic report_violation(input string what);
		$display("%s", what);
		$display("TESTS FAILED");
		$fatal(1, "stopped at first rule violation");
	endtask

	task automatic expect_equal(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else report_mismatch(test, expected, actual);
	endtask

	// ====================
	// Protocol rules
	// ====================
	a_wait_with_wr: assert property (@(posedge clk_1x) disable iff (rst)
		ram_wr |-> ioctl_wait)
		else report_violation("ioctl_wait was low during ram_wr");

	a_wait_rise: assert property (@(posedge clk_1x) disable iff (rst)
		$rose(ioctl_wait) |-> ram_wr)
		else report_violation("ioctl_wait rose without ram_wr");

	a_wait_release: assert property (@(posedge clk_1x) disable iff (rst)
		(ioctl_wait && ram_ready) |=> !ioctl_wait)
		else report_violation("ioctl_wait stayed high after ram_ready");

	a_wait_hold: assert property (@(posedge clk_1x) disable iff (rst)
		(ioctl_wait && !ram_ready && ioctl_download) |=> ioctl_wait)
		else report_violation("ioctl_wait fell before ram_ready");

	a_one_strobe: assert property (@(posedge clk_1x) disable iff (rst)
		!(pifrom_wren && ram_wr))
		else report_violation("boot-ROM and SDRAM writes fired together");

	a_p1_silenced: assert property (@(posedge clk_1x) disable iff (rst)
		joy_0[loader_pkg::SS_BUTTON] |-> (p1_bits == '0))
		else report_violation("player 1 buttons seen while savestate button held");

	a_bk_save: assert property (@(posedge clk_1x) disable iff (rst)
		bk_save == $past(bk_save_cmd || (osd_status && !autosave_off)))
		else report_violation("bk_save does not follow its request inputs");

	// SDRAM model answers each write after a random delay
	always begin
		@(negedge clk_1x);
		if (!rst && ram_wr) begin
			ready_delay = 1 + ({$random(seed)} % 5);
			repeat (ready_delay) @(posedge clk_1x);
			ram_ready <= 1'b1;
			@(posedge clk_1x);
			ram_ready <= 1'b0;
		end
	end

	// ====================
	// Host actions
	// ====================
	task automatic start_download(input logic [7:0] index);
		@(posedge clk_1x);
		ioctl_download <= 1'b1;
		ioctl_index    <= index;
	endtask

	task automatic stop_download();
		@(posedge clk_1x);
		ioctl_download <= 1'b0;
		@(posedge clk_1x);
	endtask

	// Back-to-back low and high half; returns at the negedge after the high half is sampled
	task automatic send_pair(input loader_pkg::addr_t addr, input loader_pkg::half_t lo,
		input loader_pkg::half_t hi);
		@(posedge clk_1x);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= addr;
		ioctl_dout <= lo;
		@(posedge clk_1x);
		ioctl_addr <= addr | loader_pkg::addr_t'(2);
		ioctl_dout <= hi;
		@(posedge clk_1x);
		ioctl_wr   <= 1'b0;
		@(negedge clk_1x);
	endtask

	task automatic pulse_mount(input logic readonly, input logic [31:0] size);
		@(posedge clk_1x);
		img_mounted  <= 1'b1;
		img_readonly <= readonly;
		img_size     <= size;
		@(posedge clk_1x);
		img_mounted  <= 1'b0;
		@(negedge clk_1x);
	endtask

	// ====================
	// Tests
	// ====================
	task automatic run_pifrom_test();
		loader_pkg::addr_t a;
		loader_pkg::half_t lo;
		loader_pkg::half_t hi;
		loader_pkg::word_t exp_data;
		start_download(8'(loader_pkg::IDX_PIFROM));
		for (int i = 0; i < PAIR_COUNT; i++) begin
			a  = loader_pkg::addr_t'($random(seed)) & ~loader_pkg::addr_t'(3);
			lo = loader_pkg::half_t'($random(seed));
			hi = loader_pkg::half_t'($random(seed));
			// Boot ROM holds each word fully byte reversed
			exp_data = {lo[7:0], lo[15:8], hi[7:0], hi[15:8]};
			send_pair(a, lo, hi);
			expect_equal("pif_wren_early", 0, pifrom_wren);
			@(negedge clk_1x);
			expect_equal("pif_wren", 1, pifrom_wren);
			expect_equal("pif_data", exp_data, pifrom_wrdata);
			expect_equal("pif_addr", 32'(a[10:2]), 32'(pifrom_wraddress));
			expect_equal("pif_ram_wr", 0, ram_wr);
		end
		stop_download();
	endtask

	task automatic watch_idle(input string test);
		for (int i = 0; i < 6; i++) begin
			expect_equal({test, "_pif_wren"}, 0, pifrom_wren);
			expect_equal({test, "_ram_wr"}, 0, ram_wr);
			expect_equal({test, "_wait"}, 0, ioctl_wait);
			@(negedge clk_1x);
		end
	endtask

	task automatic run_other_target_test();
		start_download(8'd5);
		send_pair(loader_pkg::addr_t'(32'h100), 16'h1234, 16'h5678);
		watch_idle("index5");
		stop_download();
		// Cartridge code selected while no download runs
		ioctl_index <= 8'(loader_pkg::IDX_CART);
		send_pair(loader_pkg::addr_t'(32'h200), 16'h9abc, 16'hdef0);
		watch_idle("no_download");
	endtask

	task automatic run_backup_test();
		logic [4:0] req;
		pulse_mount(1'b1, 32'h4000);
		expect_equal("use_img_readonly", 0, use_img);
		pulse_mount(1'b0, 32'h0);
		expect_equal("use_img_empty", 0, use_img);
		pulse_mount(1'b0, 32'h8000);
		expect_equal("use_img_writable", 1, use_img);
		for (int i = 0; i < 24; i++) begin
			req = 5'($random(seed));
			@(posedge clk_1x);
			bk_load_cmd  <= req[0];
			bk_save_cmd  <= req[1];
			autosave_off <= req[2];
			osd_status   <= req[3];
			bk_pending   <= req[4];
			@(negedge clk_1x);
			expect_equal("led_busy_pending", req[4], led_busy);
			@(posedge clk_1x);
			@(negedge clk_1x);
			expect_equal("bk_load_cmd", req[0], bk_load);
		end
		@(posedge clk_1x);
		bk_load_cmd  <= 1'b0;
		bk_save_cmd  <= 1'b0;
		autosave_off <= 1'b0;
		osd_status   <= 1'b0;
		bk_pending   <= 1'b0;
	endtask

	task automatic run_cart_test();
		loader_pkg::addr_t a;
		loader_pkg::addr_t exp_addr;
		loader_pkg::half_t lo;
		loader_pkg::half_t hi;
		expect_equal("cart_loaded_before", 0, cart_loaded);
		expect_equal("use_img_before_cart", 1, use_img);
		start_download(8'(loader_pkg::IDX_CART));
		wait_count = 0;
		while (use_img) begin
			@(negedge clk_1x);
			wait_count++;
			if (wait_count > WAIT_LIMIT) begin
				report_violation("use_img was not cleared by the cartridge download");
			end
		end
		expect_equal("cart_led_busy", 1, led_busy);
		// Mount during the download asks for a backup load
		@(posedge clk_1x);
		img_mounted  <= 1'b1;
		img_readonly <= 1'b1;
		@(posedge clk_1x);
		img_mounted  <= 1'b0;
		@(negedge clk_1x);
		expect_equal("bk_load_cart_mount", 1, bk_load);
		for (int i = 0; i < PAIR_COUNT; i++) begin
			a  = loader_pkg::addr_t'($random(seed)) & ~loader_pkg::addr_t'(3);
			lo = loader_pkg::half_t'($random(seed));
			hi = loader_pkg::half_t'($random(seed));
			exp_addr = a + loader_pkg::CART_BASE;
			send_pair(a, lo, hi);
			expect_equal("cart_ram_wr_early", 0, ram_wr);
			@(negedge clk_1x);
			expect_equal("cart_ram_wr", 1, ram_wr);
			expect_equal("cart_wait_rise", 1, ioctl_wait);
			expect_equal("cart_data", {hi, lo}, ram_data);
			expect_equal("cart_addr", 32'(exp_addr), 32'(ram_addr));
			expect_equal("cart_pif_wren", 0, pifrom_wren);
			expect_equal("cart_led_busy", 1, led_busy);
			wait_count = 0;
			while (ioctl_wait) begin
				@(negedge clk_1x);
				wait_count++;
				if (wait_count > WAIT_LIMIT) begin
					report_violation("ioctl_wait stuck high after ram_wr");
				end
			end
		end
		stop_download();
		img_readonly <= 1'b0;
		@(negedge clk_1x);
		expect_equal("cart_loaded_after", 1, cart_loaded);
	endtask

	// Model of one button vector, player 1 in bit 0
	function automatic loader_pkg::pad_vec_t expected_pad(input int pos);
		loader_pkg::pad_vec_t v;
		v[0] = joy_0[pos[4:0]] && !joy_0[loader_pkg::SS_BUTTON];
		v[1] = joy_1[pos[4:0]];
		v[2] = joy_2[pos[4:0]];
		v[3] = joy_3[pos[4:0]];
		return v;
	endfunction

	task automatic check_pad(input string name, input int pos, input loader_pkg::pad_vec_t act);
		expect_equal(name, 32'(expected_pad(pos)), 32'(act));
	endtask

	task automatic run_pad_test();
		loader_pkg::joy_t j0;
		for (int i = 0; i < 32; i++) begin
			j0 = loader_pkg::joy_t'($random(seed));
			// Alternate the savestate button so both cases are covered
			j0[loader_pkg::SS_BUTTON] = i[0];
			@(posedge clk_1x);
			joy_0 <= j0;
			joy_1 <= loader_pkg::joy_t'($random(seed));
			joy_2 <= loader_pkg::joy_t'($random(seed));
			joy_3 <= loader_pkg::joy_t'($random(seed));
			@(negedge clk_1x);
			check_pad("pad_a", loader_pkg::BTN_A, pad_a);
			check_pad("pad_b", loader_pkg::BTN_B, pad_b);
			check_pad("pad_z", loader_pkg::BTN_Z, pad_z);
			check_pad("pad_start", loader_pkg::BTN_START, pad_start);
			check_pad("pad_dpad_up", loader_pkg::BTN_UP, pad_dpad_up);
			check_pad("pad_dpad_down", loader_pkg::BTN_DOWN, pad_dpad_down);
			check_pad("pad_dpad_left", loader_pkg::BTN_LEFT, pad_dpad_left);
			check_pad("pad_dpad_right", loader_pkg::BTN_RIGHT, pad_dpad_right);
			check_pad("pad_l", loader_pkg::BTN_L, pad_l);
			check_pad("pad_r", loader_pkg::BTN_R, pad_r);
			check_pad("pad_c_up", loader_pkg::BTN_C_UP, pad_c_up);
			check_pad("pad_c_down", loader_pkg::BTN_C_DOWN, pad_c_down);
			check_pad("pad_c_left", loader_pkg::BTN_C_LEFT, pad_c_left);
			check_pad("pad_c_right", loader_pkg::BTN_C_RIGHT, pad_c_right);
		end
	endtask

	// ====================
	// Sequence
	// ====================
	initial begin
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		ram_ready      = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		bk_load_cmd    = 1'b0;
		bk_save_cmd    = 1'b0;
		autosave_off   = 1'b0;
		osd_status     = 1'b0;
		bk_pending     = 1'b0;
		joy_0          = '0;
		joy_1          = '0;
		joy_2          = '0;
		joy_3          = '0;
		wait_count     = 0;
		@(negedge clk_1x);
		while (rst !== 1'b0) begin
			@(negedge clk_1x);
			wait_count++;
			if (wait_count > WAIT_LIMIT) begin
				report_violation("reset was never released");
			end
		end
		expect_equal("reset_pifrom_wren", 0, pifrom_wren);
		expect_equal("reset_ram_wr", 0, ram_wr);
		expect_equal("reset_ioctl_wait", 0, ioctl_wait);
		expect_equal("reset_cart_loaded", 0, cart_loaded);
		expect_equal("reset_use_img", 0, use_img);
		expect_equal("reset_led_busy", 0, led_busy);
		run_pifrom_test();
		run_other_target_test();
		run_backup_test();
		run_cart_test();
		run_pad_test();
		@(negedge clk_1x);
		$display("TESTS PASSED");
		$finish;
	end

	// Guard against a run that never finishes
	initial begin
		for (int n = 0; n < RUN_LIMIT; n++) begin
			@(posedge clk_1x);
		end
		report_violation("simulation ran past its cycle limit");
	end

endmodule

// File: build.f
hw/loader_pkg.sv
hw/word_bus_if.sv
hw/download_ctrl.sv
hw/word_packer.sv
hw/pad_mapper.sv
hw/core_loader_top.sv
test/tb_clock_gen.sv
test/tb_core_loader.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line in its output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_core_loader -f build.f &&
./obj_dir/Vtb_core_loader | tee /dev/stderr | grep -q "TESTS PASSED" &&
echo "Simulation run passed" ||
{
	echo "Simulation run failed"
	exit 1
}
